// File: source/rv_issue_config.svh
`ifndef RV_ISSUE_CONFIG_SVH
`define RV_ISSUE_CONFIG_SVH

`define XLEN        32 // data word width
`define REG_BITS    5
`define TAG_BITS    4  // tag 0 marks a register that is not waiting on the ROB
`define ROB_ENTRIES 16
`define IQ_DEPTH    8

`endif

// File: source/rv32i_pkg.sv
`include "rv_issue_config.svh"

package rv32i_pkg;

    typedef logic [`XLEN-1:0]     rv32i_word;
    typedef logic [`REG_BITS-1:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011, // register and immediate arithmetic
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        add  = 3'b000, // sub in register form when funct7 bit 5 is set
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // funct7 bit 5 selects the arithmetic shift
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // sub and sra sit on the slt and sltu codes, which never reach the ALU station
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_sra = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

endpackage

// File: source/ooo_pkg.sv
`include "rv_issue_config.svh"

package ooo_pkg;

    typedef logic [`TAG_BITS-1:0] tag_t; // names a ROB entry

    typedef enum logic {
        REG = 1'b0, // result goes to a register
        BR  = 1'b1  // resolves a branch prediction
    } op_type_t;

endpackage

// File: source/inst_queue.sv
`timescale 1ns/10ps
`include "rv_issue_config.svh"

module inst_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_push,
    input  rv32i_pkg::rv32i_word i_pc,
    input  rv32i_pkg::rv32i_word i_inst,
    input  logic                 i_br_pred,
    input  logic                 i_pop,
    output logic                 o_full,
    output logic                 o_valid,
    output rv32i_pkg::rv32i_word o_pc,
    output rv32i_pkg::rv32i_word o_inst,
    output logic                 o_br_pred
);
    import rv32i_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    rv32i_word            pc_mem   [`IQ_DEPTH];
    rv32i_word            inst_mem [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] pred_mem;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`IQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_full  = (count == CNT_W'(`IQ_DEPTH));
    assign o_valid = (count != '0);
    assign do_push = i_push && !o_full; // a push into a full queue is dropped
    assign do_pop  = i_pop && o_valid;

    assign o_pc      = pc_mem[rd_ptr];
    assign o_inst    = inst_mem[rd_ptr];
    assign o_br_pred = pred_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // both or neither leave the fill level alone
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= i_pc;
            inst_mem[wr_ptr] <= i_inst;
            pred_mem[wr_ptr] <= i_br_pred;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(i_push && o_full))
        else $error("inst_queue: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(i_pop && !o_valid))
        else $error("inst_queue: pop while empty");

endmodule

// File: source/inst_fields.sv
`timescale 1ns/10ps

module inst_fields (
    input  rv32i_pkg::rv32i_word   i_inst,
    output rv32i_pkg::rv32i_opcode o_opcode,
    output logic [2:0]             o_funct3,
    output logic                   o_funct7_b5,
    output rv32i_pkg::rv32i_reg    o_rs1,
    output rv32i_pkg::rv32i_reg    o_rs2,
    output rv32i_pkg::rv32i_reg    o_rd,
    output rv32i_pkg::rv32i_word   o_i_imm,
    output rv32i_pkg::rv32i_word   o_b_imm,
    output rv32i_pkg::rv32i_word   o_u_imm
);
    import rv32i_pkg::*;

    assign o_opcode    = rv32i_opcode'(i_inst[6:0]);
    assign o_funct3    = i_inst[14:12];
    assign o_funct7_b5 = i_inst[30]; // only bit of funct7 that the kept opcodes look at

    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];
    assign o_rd  = i_inst[11:7];

    assign o_i_imm = {{21{i_inst[31]}}, i_inst[30:20]};
    assign o_b_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign o_u_imm = {i_inst[31:12], 12'h000};

endmodule

// File: source/operand_bypass.sv
`timescale 1ns/10ps
`include "rv_issue_config.svh"

module operand_bypass (
    input  ooo_pkg::tag_t                                 i_reg_q,
    input  rv32i_pkg::rv32i_word                          i_reg_v,
    input  logic [`ROB_ENTRIES-1:0]                       i_rob_ready,
    input  rv32i_pkg::rv32i_word [`ROB_ENTRIES-1:0]       i_rob_vals,
    output ooo_pkg::tag_t                                 o_q,
    output rv32i_pkg::rv32i_word                          o_v
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic      hit;
    rv32i_word rob_val;

    // the producer already wrote back, so the operand no longer waits on the CDB
    assign hit     = (i_reg_q != '0) && i_rob_ready[i_reg_q];
    assign rob_val = i_rob_vals[i_reg_q];

    assign o_q = hit ? tag_t'(0) : i_reg_q;
    assign o_v = hit ? rob_val : i_reg_v;

endmodule

// File: source/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_valid,
    input  rv32i_pkg::rv32i_word      i_pc,
    input  logic                      i_br_pred,
    input  rv32i_pkg::rv32i_opcode    i_opcode,
    input  logic [2:0]                i_funct3,
    input  logic                      i_funct7_b5,
    input  rv32i_pkg::rv32i_reg       i_rd,
    input  rv32i_pkg::rv32i_word      i_i_imm,
    input  rv32i_pkg::rv32i_word      i_b_imm,
    input  rv32i_pkg::rv32i_word      i_u_imm,
    input  ooo_pkg::tag_t             i_qj,
    input  ooo_pkg::tag_t             i_qk,
    input  rv32i_pkg::rv32i_word      i_vj,
    input  rv32i_pkg::rv32i_word      i_vk,
    input  ooo_pkg::tag_t             i_tag_free,
    input  logic                      i_alu_ready,
    input  logic                      i_cmp_ready,
    output logic                      o_shift,
    output logic                      o_load_tag,
    output ooo_pkg::tag_t             o_tag_out,
    output rv32i_pkg::rv32i_reg       o_rd_out,
    output logic                      o_rob_valid,
    output ooo_pkg::op_type_t         o_rob_op,
    output rv32i_pkg::rv32i_reg       o_rob_dest,
    output logic                      o_alu_valid,
    output rv32i_pkg::alu_ops         o_alu_op,
    output rv32i_pkg::rv32i_word      o_alu_vj,
    output rv32i_pkg::rv32i_word      o_alu_vk,
    output ooo_pkg::tag_t             o_alu_qj,
    output ooo_pkg::tag_t             o_alu_qk,
    output ooo_pkg::tag_t             o_alu_dest,
    output logic                      o_cmp_valid,
    output logic                      o_cmp_is_br,
    output rv32i_pkg::branch_funct3_t o_cmp_op,
    output rv32i_pkg::rv32i_word      o_cmp_vj,
    output rv32i_pkg::rv32i_word      o_cmp_vk,
    output ooo_pkg::tag_t             o_cmp_qj,
    output ooo_pkg::tag_t             o_cmp_qk,
    output ooo_pkg::tag_t             o_cmp_dest,
    output rv32i_pkg::rv32i_word      o_cmp_pc,
    output rv32i_pkg::rv32i_word      o_cmp_b_imm,
    output logic                      o_cmp_br_pred
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic           known;
    logic           to_cmp;
    logic           is_br;
    logic           discard;
    logic           issue;
    alu_ops         alu_op;
    branch_funct3_t cmp_op;
    rv32i_word      vj;
    rv32i_word      vk;
    tag_t           qj;
    tag_t           qk;

    always_comb begin
        known  = 1'b1;
        to_cmp = 1'b0;
        is_br  = 1'b0;
        alu_op = alu_add;
        cmp_op = blt;
        vj     = i_vj;
        vk     = i_vk;
        qj     = i_qj;
        qk     = i_qk;
        case (i_opcode)
            op_imm, op_reg: begin
                if (i_opcode == op_imm) begin
                    vk = i_i_imm; // the immediate takes the place of rs2
                    qk = '0;
                end
                case (arith_funct3_t'(i_funct3))
                    slt: begin
                        to_cmp = 1'b1;
                        cmp_op = blt;
                    end
                    sltu: begin
                        to_cmp = 1'b1;
                        cmp_op = bltu;
                    end
                    add: begin
                        alu_op = (i_opcode == op_reg && i_funct7_b5) ? alu_sub : alu_add;
                    end
                    sr: begin
                        alu_op = i_funct7_b5 ? alu_sra : alu_srl;
                    end
                    default: begin
                        alu_op = alu_ops'(i_funct3);
                    end
                endcase
            end
            op_lui, op_auipc: begin
                vj = (i_opcode == op_auipc) ? i_pc : '0;
                vk = i_u_imm;
                qj = '0;
                qk = '0;
            end
            op_jal: begin
                vj = i_pc; // link value is pc + 4
                vk = rv32i_word'(4);
                qj = '0;
                qk = '0;
            end
            op_br: begin
                to_cmp = 1'b1;
                is_br  = 1'b1;
                cmp_op = branch_funct3_t'(i_funct3);
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // writes to x0 and unknown opcodes leave the queue without a dispatch
    assign discard = !known || (i_rd == '0 && !is_br);
    assign issue   = i_valid && !discard && (i_tag_free != '0)
                     && (to_cmp ? i_cmp_ready : i_alu_ready);

    assign o_shift    = issue || (i_valid && discard);
    assign o_load_tag = issue && !is_br;
    assign o_tag_out  = o_load_tag ? i_tag_free : '0;
    assign o_rd_out   = o_load_tag ? i_rd : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rob_valid <= 1'b0;
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
        end else begin
            o_rob_valid <= issue;
            o_alu_valid <= issue && !to_cmp;
            o_cmp_valid <= issue && to_cmp;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_rob_op      <= is_br ? BR : REG;
            o_rob_dest    <= i_rd;
            o_alu_op      <= alu_op;
            o_alu_vj      <= vj;
            o_alu_vk      <= vk;
            o_alu_qj      <= qj;
            o_alu_qk      <= qk;
            o_alu_dest    <= i_tag_free;
            o_cmp_is_br   <= is_br;
            o_cmp_op      <= cmp_op;
            o_cmp_vj      <= vj;
            o_cmp_vk      <= vk;
            o_cmp_qj      <= qj;
            o_cmp_qk      <= qk;
            o_cmp_dest    <= i_tag_free;
            o_cmp_pc      <= is_br ? i_pc : '0; // set-less-than has no branch target
            o_cmp_b_imm   <= is_br ? i_b_imm : '0;
            o_cmp_br_pred <= is_br && i_br_pred;
        end
    end

    a_one_station: assert property (@(posedge clk) disable iff (rst)
        !(o_alu_valid && o_cmp_valid))
        else $error("issue_ctrl: both stations got a dispatch");

    a_tag_with_shift: assert property (@(posedge clk) disable iff (rst)
        o_load_tag |-> o_shift ##1 (o_rob_valid && o_rob_op == REG))
        else $error("issue_ctrl: tag load without a matching pop and ROB entry");

endmodule

// File: source/rv_issue_top.sv
`timescale 1ns/10ps
`include "rv_issue_config.svh"

module rv_issue_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_push,
    input  rv32i_pkg::rv32i_word                    i_pc,
    input  rv32i_pkg::rv32i_word                    i_inst,
    input  logic                                    i_br_pred,
    output logic                                    o_full,
    output rv32i_pkg::rv32i_reg                     o_rs1,
    output rv32i_pkg::rv32i_reg                     o_rs2,
    input  ooo_pkg::tag_t                           i_reg_qj,
    input  ooo_pkg::tag_t                           i_reg_qk,
    input  rv32i_pkg::rv32i_word                    i_reg_vj,
    input  rv32i_pkg::rv32i_word                    i_reg_vk,
    output logic                                    o_load_tag,
    output ooo_pkg::tag_t                           o_tag_out,
    output rv32i_pkg::rv32i_reg                     o_rd_out,
    input  ooo_pkg::tag_t                           i_rob_tag_ready,
    input  logic [`ROB_ENTRIES-1:0]                 i_rob_ready,
    input  rv32i_pkg::rv32i_word [`ROB_ENTRIES-1:0] i_rob_vals,
    output logic                                    o_rob_valid,
    output ooo_pkg::op_type_t                       o_rob_op,
    output rv32i_pkg::rv32i_reg                     o_rob_dest,
    input  logic                                    i_alu_ready,
    input  logic                                    i_cmp_ready,
    output logic                                    o_alu_valid,
    output rv32i_pkg::alu_ops                       o_alu_op,
    output rv32i_pkg::rv32i_word                    o_alu_vj,
    output rv32i_pkg::rv32i_word                    o_alu_vk,
    output ooo_pkg::tag_t                           o_alu_qj,
    output ooo_pkg::tag_t                           o_alu_qk,
    output ooo_pkg::tag_t                           o_alu_dest,
    output logic                                    o_cmp_valid,
    output logic                                    o_cmp_is_br,
    output rv32i_pkg::branch_funct3_t               o_cmp_op,
    output rv32i_pkg::rv32i_word                    o_cmp_vj,
    output rv32i_pkg::rv32i_word                    o_cmp_vk,
    output ooo_pkg::tag_t                           o_cmp_qj,
    output ooo_pkg::tag_t                           o_cmp_qk,
    output ooo_pkg::tag_t                           o_cmp_dest,
    output rv32i_pkg::rv32i_word                    o_cmp_pc,
    output rv32i_pkg::rv32i_word                    o_cmp_b_imm,
    output logic                                    o_cmp_br_pred
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic        head_valid;
    rv32i_word   head_pc;
    rv32i_word   head_inst;
    logic        head_br_pred;
    logic        shift;
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        funct7_b5;
    rv32i_reg    rd;
    rv32i_word   i_imm;
    rv32i_word   b_imm;
    rv32i_word   u_imm;
    tag_t        qj;
    tag_t        qk;
    rv32i_word   vj;
    rv32i_word   vk;

    inst_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .i_push    (i_push),
        .i_pc      (i_pc),
        .i_inst    (i_inst),
        .i_br_pred (i_br_pred),
        .i_pop     (shift),
        .o_full    (o_full),
        .o_valid   (head_valid),
        .o_pc      (head_pc),
        .o_inst    (head_inst),
        .o_br_pred (head_br_pred)
    );

    inst_fields u_fields (
        .i_inst      (head_inst),
        .o_opcode    (opcode),
        .o_funct3    (funct3),
        .o_funct7_b5 (funct7_b5),
        .o_rs1       (o_rs1), // register file answers in the same cycle
        .o_rs2       (o_rs2),
        .o_rd        (rd),
        .o_i_imm     (i_imm),
        .o_b_imm     (b_imm),
        .o_u_imm     (u_imm)
    );

    operand_bypass u_bypass_j (
        .i_reg_q     (i_reg_qj),
        .i_reg_v     (i_reg_vj),
        .i_rob_ready (i_rob_ready),
        .i_rob_vals  (i_rob_vals),
        .o_q         (qj),
        .o_v         (vj)
    );

    operand_bypass u_bypass_k (
        .i_reg_q     (i_reg_qk),
        .i_reg_v     (i_reg_vk),
        .i_rob_ready (i_rob_ready),
        .i_rob_vals  (i_rob_vals),
        .o_q         (qk),
        .o_v         (vk)
    );

    // dispatch, register-file and ROB outputs share their names with the top ports
    issue_ctrl u_ctrl (
        .i_valid     (head_valid),
        .i_pc        (head_pc),
        .i_br_pred   (head_br_pred),
        .i_opcode    (opcode),
        .i_funct3    (funct3),
        .i_funct7_b5 (funct7_b5),
        .i_rd        (rd),
        .i_i_imm     (i_imm),
        .i_b_imm     (b_imm),
        .i_u_imm     (u_imm),
        .i_qj        (qj),
        .i_qk        (qk),
        .i_vj        (vj),
        .i_vk        (vk),
        .i_tag_free  (i_rob_tag_ready),
        .o_shift     (shift),
        .*
    );

endmodule

// File: sim/issue_vectors.svh
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

// columns: inst, pc, pred, qj, qk, free tag, rob ready mask, rob value at qj, alu ready,
// cmp ready, stall group (1 station, 2 tag), expected station (1 alu, 2 cmp), expected op
task automatic load_rows();
    add_row(enc_r(7'h00, 2, 1, 3'd0, 3), 32'h100, 0, 0, 0, 5, 0, 0, 1, 1, 0, 1, 3'd0);
    add_row(enc_r(7'h20, 5, 4, 3'd0, 6), 32'h104, 0, 0, 0, 6, 0, 0, 1, 1, 0, 1, 3'd2);
    add_row(enc_r(7'h00, 8, 7, 3'd1, 9), 32'h108, 0, 0, 0, 7, 0, 0, 1, 1, 0, 1, 3'd1);
    add_row(enc_r(7'h00, 11, 10, 3'd5, 12), 32'h10c, 0, 0, 0, 8, 0, 0, 1, 1, 0, 1, 3'd5);
    add_row(enc_r(7'h20, 14, 13, 3'd5, 15), 32'h110, 0, 0, 0, 9, 0, 0, 1, 1, 0, 1, 3'd3);
    add_row(enc_r(7'h00, 17, 16, 3'd4, 18), 32'h114, 0, 0, 0, 10, 0, 0, 1, 1, 0, 1, 3'd4);
    add_row(enc_r(7'h00, 20, 19, 3'd6, 21), 32'h118, 0, 0, 0, 11, 0, 0, 1, 1, 0, 1, 3'd6);
    add_row(enc_r(7'h00, 23, 22, 3'd7, 24), 32'h11c, 0, 0, 0, 12, 0, 0, 1, 1, 0, 1, 3'd7);
    add_row(enc_i(12'hff0, 1, 3'd0, 5), 32'h120, 0, 0, 0, 13, 0, 0, 1, 1, 0, 1, 3'd0);
    add_row(enc_i(12'h403, 2, 3'd5, 6), 32'h124, 0, 0, 0, 14, 0, 0, 1, 1, 0, 1, 3'd3);
    add_row(enc_i(12'h0f5, 3, 3'd4, 7), 32'h128, 0, 0, 0, 15, 0, 0, 1, 1, 0, 1, 3'd4);
    add_row(enc_u(7'b0110111, 20'habcde, 7), 32'h12c, 0, 0, 0, 1, 0, 0, 1, 1, 0, 1, 3'd0);
    add_row(enc_u(7'b0010111, 20'h00012, 8), 32'h130, 0, 0, 0, 2, 0, 0, 1, 1, 0, 1, 3'd0);
    add_row(enc_u(7'b1101111, 20'h0c840, 1), 32'h134, 0, 0, 0, 3, 0, 0, 1, 1, 0, 1, 3'd0);
    // set-less-than goes to the compare station
    add_row(enc_r(7'h00, 3, 2, 3'd2, 4), 32'h138, 0, 0, 0, 4, 0, 0, 1, 1, 0, 2, 3'd4);
    add_row(enc_r(7'h00, 6, 5, 3'd3, 7), 32'h13c, 0, 0, 0, 5, 0, 0, 1, 1, 0, 2, 3'd6);
    add_row(enc_i(12'h800, 8, 3'd2, 9), 32'h140, 0, 0, 0, 6, 0, 0, 1, 1, 0, 2, 3'd4);
    add_row(enc_i(12'h7ff, 10, 3'd3, 11), 32'h144, 0, 0, 0, 7, 0, 0, 1, 1, 0, 2, 3'd6);
    add_row(enc_b(13'h0010, 2, 1, 3'd0), 32'h148, 1, 0, 0, 8, 0, 0, 1, 1, 0, 2, 3'd0);
    add_row(enc_b(13'h1ff0, 4, 3, 3'd6), 32'h14c, 0, 2, 0, 9, 0, 0, 1, 1, 0, 2, 3'd6);
    add_row(enc_r(7'h00, 26, 25, 3'd0, 27), 32'h150, 0, 3, 7, 10, 16'h0008, 32'hdeadbeef,
            1, 1, 0, 1, 3'd0);
    add_row(enc_i(12'h001, 1, 3'd0, 0), 32'h154, 0, 0, 0, 11, 0, 0, 1, 1, 0, 0, 3'd0);
    add_row(enc_r(7'h00, 29, 28, 3'd0, 30), 32'h158, 0, 0, 0, 12, 0, 0, 1, 1, 0, 1, 3'd0);
    // held back by the stations until the queue is full, then by an empty free list
    add_row(enc_u(7'b0110111, 20'h00fff, 10), 32'h200, 0, 0, 0, 9, 0, 0, 1, 1, 1, 1, 3'd0);
    add_row(enc_i(12'h123, 12, 3'd0, 11), 32'h204, 0, 0, 0, 9, 0, 0, 1, 1, 1, 1, 3'd0);
    add_row(enc_r(7'h00, 15, 14, 3'd2, 13), 32'h208, 0, 0, 2, 9, 0, 0, 1, 1, 1, 2, 3'd4);
    add_row(enc_b(13'h0020, 17, 16, 3'd1), 32'h20c, 1, 0, 0, 9, 0, 0, 1, 1, 1, 2, 3'd1);
    add_row(enc_r(7'h00, 3, 2, 3'd4, 5), 32'h210, 0, 0, 0, 9, 0, 0, 1, 1, 1, 1, 3'd4);
    add_row(enc_i(12'hfff, 4, 3'd6, 6), 32'h214, 0, 5, 0, 9, 0, 0, 1, 1, 1, 1, 3'd6);
    add_row(enc_r(7'h20, 7, 6, 3'd5, 8), 32'h218, 0, 0, 0, 9, 0, 0, 1, 1, 1, 1, 3'd3);
    add_row(enc_u(7'b1101111, 20'h00100, 9), 32'h21c, 0, 0, 0, 9, 0, 0, 1, 1, 1, 1, 3'd0);
    add_row(enc_r(7'h00, 19, 18, 3'd7, 20), 32'h300, 0, 0, 0, 11, 0, 0, 1, 1, 2, 1, 3'd7);
    add_row(enc_i(12'h00f, 22, 3'd3, 21), 32'h304, 0, 0, 0, 11, 0, 0, 1, 1, 2, 2, 3'd6);
    add_row(enc_u(7'b0010111, 20'h80000, 23), 32'h308, 0, 0, 0, 11, 0, 0, 1, 1, 2, 1, 3'd0);
endtask

`endif

// File: sim/issue_tb.sv
`timescale 1ns/10ps
`include "rv_issue_config.svh"

module issue_tb;

    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BR  = 7'b1100011;

    logic clk = 1'b0;
    logic rst;
    logic i_push;
    logic [31:0] i_pc;
    logic [31:0] i_inst;
    logic i_br_pred;
    logic o_full;
    logic [4:0] o_rs1;
    logic [4:0] o_rs2;
    logic [3:0] i_reg_qj;
    logic [3:0] i_reg_qk;
    logic [31:0] i_reg_vj;
    logic [31:0] i_reg_vk;
    logic o_load_tag;
    logic [3:0] o_tag_out;
    logic [4:0] o_rd_out;
    logic [3:0] i_rob_tag_ready;
    logic [`ROB_ENTRIES-1:0] i_rob_ready;
    logic [`ROB_ENTRIES-1:0][31:0] i_rob_vals;
    logic o_rob_valid;
    logic o_rob_op;
    logic [4:0] o_rob_dest;
    logic i_alu_ready;
    logic i_cmp_ready;
    logic o_alu_valid;
    logic [2:0] o_alu_op;
    logic [31:0] o_alu_vj;
    logic [31:0] o_alu_vk;
    logic [3:0] o_alu_qj;
    logic [3:0] o_alu_qk;
    logic [3:0] o_alu_dest;
    logic o_cmp_valid;
    logic o_cmp_is_br;
    logic [2:0] o_cmp_op;
    logic [31:0] o_cmp_vj;
    logic [31:0] o_cmp_vk;
    logic [3:0] o_cmp_qj;
    logic [3:0] o_cmp_qk;
    logic [3:0] o_cmp_dest;
    logic [31:0] o_cmp_pc;
    logic [31:0] o_cmp_b_imm;
    logic o_cmp_br_pred;

    logic [31:0] t_inst[$];
    logic [31:0] t_pc[$];
    logic [31:0] t_rob_val[$];
    logic [15:0] t_mask[$];
    logic [3:0] t_qj[$];
    logic [3:0] t_qk[$];
    logic [3:0] t_free[$];
    logic [2:0] t_op[$];
    logic t_pred[$];
    logic t_alu[$];
    logic t_cmp[$];
    int t_stall[$];
    int t_st[$];

    logic [3:0] reg_q[32]; // register file model, read at the head's rs1 and rs2
    logic [31:0] reg_v[32];
    int exp_q[$];
    int tag_q[$];
    logic [31:0] lfsr = 32'h9f1e;
    int errors = 0;
    logic holding = 1'b0;
    logic loaded = 1'b0;

    rv_issue_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // taps 32 22 2 1
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input logic pred,
                           input logic [3:0] qj, input logic [3:0] qk, input logic [3:0] free,
                           input logic [15:0] mask, input logic [31:0] rob_val,
                           input logic alu, input logic cmp, input int stall, input int st,
                           input logic [2:0] op);
        t_inst.push_back(inst);
        t_pc.push_back(pc);
        t_pred.push_back(pred);
        t_qj.push_back(qj);
        t_qk.push_back(qk);
        t_free.push_back(free);
        t_mask.push_back(mask);
        t_rob_val.push_back(rob_val);
        t_alu.push_back(alu);
        t_cmp.push_back(cmp);
        t_stall.push_back(stall);
        t_st.push_back(st);
        t_op.push_back(op);
    endtask

    `include "issue_vectors.svh"

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic push_row(input int r);
        logic [6:0] opc;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        opc = t_inst[r][6:0];
        rs1 = t_inst[r][19:15];
        rs2 = t_inst[r][24:20];
        rd  = t_inst[r][11:7];
        if (opc == OPC_OP || opc == OPC_BR || opc == OPC_IMM) begin
            reg_q[rs1] = t_qj[r];
            reg_v[rs1] = rand_word(32);
        end
        if (opc == OPC_OP || opc == OPC_BR) begin
            reg_q[rs2] = t_qk[r];
            reg_v[rs2] = rand_word(32);
        end
        i_rob_ready = t_mask[r];
        if (t_qj[r] != 0) begin
            i_rob_vals[t_qj[r]] = t_rob_val[r];
        end
        i_push    = 1'b1;
        i_pc      = t_pc[r];
        i_inst    = t_inst[r];
        i_br_pred = (opc == OPC_BR) ? t_pred[r] : rand_word(1);
        if (t_st[r] != 0) begin
            exp_q.push_back(r);
            if (rd != 0 && opc != OPC_BR) begin
                tag_q.push_back(r);
            end
        end
    endtask

    task automatic check_dispatch(input int r);
        logic [31:0] in;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [3:0] qj;
        logic [3:0] qk;
        logic is_br;
        in = t_inst[r];
        qj = t_qj[r];
        qk = t_qk[r];
        vj = reg_v[in[19:15]];
        vk = reg_v[in[24:20]];
        is_br = (in[6:0] == OPC_BR);
        if (qj != 0 && i_rob_ready[qj]) begin // value already in the ROB
            vj = i_rob_vals[qj];
            qj = '0;
        end
        if (qk != 0 && i_rob_ready[qk]) begin
            vk = i_rob_vals[qk];
            qk = '0;
        end
        case (in[6:0])
            OPC_IMM: begin
                vk = {{20{in[31]}}, in[31:20]};
                qk = '0;
            end
            7'b0110111, 7'b0010111: begin
                vj = (in[6:0] == 7'b0010111) ? t_pc[r] : 32'h0;
                vk = {in[31:12], 12'h000};
                qj = '0;
                qk = '0;
            end
            7'b1101111: begin
                vj = t_pc[r];
                vk = 32'd4;
                qj = '0;
                qk = '0;
            end
            default: ;
        endcase
        check("o_alu_valid", o_alu_valid, t_st[r] == 1);
        check("o_cmp_valid", o_cmp_valid, t_st[r] == 2);
        check("o_rob_valid", o_rob_valid, 1'b1);
        check("o_rob_op", o_rob_op, is_br);
        check("o_rob_dest", o_rob_dest, in[11:7]);
        if (t_st[r] == 1) begin
            check("o_alu_op", o_alu_op, t_op[r]);
            check("o_alu_vj", o_alu_vj, vj);
            check("o_alu_vk", o_alu_vk, vk);
            check("o_alu_qj", o_alu_qj, qj);
            check("o_alu_qk", o_alu_qk, qk);
            check("o_alu_dest", o_alu_dest, t_free[r]);
        end else begin
            check("o_cmp_op", o_cmp_op, t_op[r]);
            check("o_cmp_is_br", o_cmp_is_br, is_br);
            check("o_cmp_vj", o_cmp_vj, vj);
            check("o_cmp_vk", o_cmp_vk, vk);
            check("o_cmp_qj", o_cmp_qj, qj);
            check("o_cmp_qk", o_cmp_qk, qk);
            check("o_cmp_dest", o_cmp_dest, t_free[r]);
            check("o_cmp_pc", o_cmp_pc, is_br ? t_pc[r] : 32'h0);
            check("o_cmp_b_imm", o_cmp_b_imm,
                  is_br ? {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0} : 32'h0);
            check("o_cmp_br_pred", o_cmp_br_pred, is_br && t_pred[r]);
        end
    endtask

    always @(negedge clk) begin
        i_reg_qj <= reg_q[o_rs1];
        i_reg_vj <= reg_v[o_rs1];
        i_reg_qk <= reg_q[o_rs2];
        i_reg_vk <= reg_v[o_rs2];
        if (!rst) begin
            if (o_alu_valid || o_cmp_valid) begin
                if (holding || exp_q.size() == 0) begin
                    errors++;
                    $display("a dispatch came out when none was expected");
                end else begin
                    check_dispatch(exp_q.pop_front());
                end
            end else if (o_rob_valid) begin
                errors++;
                $display("the ROB got an entry without a dispatch");
            end
        end
    end

    // the tag load is combinational, so it is looked at just before the edge that pops the head
    always @(posedge clk) begin
        if (!rst && o_load_tag) begin
            if (holding || tag_q.size() == 0) begin
                errors++;
                $display("a tag was loaded when none was expected");
            end else begin
                check("o_tag_out", o_tag_out, t_free[tag_q[0]]);
                check("o_rd_out", o_rd_out, t_inst[tag_q.pop_front()][11:7]);
            end
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || tag_q.size() != 0) && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (n >= 10) begin
            errors++;
            $display("an expected dispatch never arrived");
            exp_q.delete();
            tag_q.delete();
        end
    endtask

    initial begin
        wait (loaded);
        #((t_inst.size() * 20 + 50) * 40);
        $display("the run took too long and was stopped");
        $display("Something failed");
        $finish;
    end

    initial begin
        int r;
        int k;
        int first;
        rst = 1'b1;
        i_push = 1'b0;
        i_pc = '0;
        i_inst = '0;
        i_br_pred = 1'b0;
        i_reg_qj = '0;
        i_reg_qk = '0;
        i_reg_vj = '0;
        i_reg_vk = '0;
        i_rob_tag_ready = '0;
        i_rob_ready = '0;
        i_alu_ready = 1'b0;
        i_cmp_ready = 1'b0;
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            i_rob_vals[i] = rand_word(32);
        end
        for (int i = 0; i < 32; i++) begin
            reg_q[i] = '0;
            reg_v[i] = rand_word(32);
        end
        load_rows();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        r = 0;
        while (r < t_inst.size()) begin
            k = t_stall[r];
            if (k == 0) begin
                @(negedge clk);
                i_alu_ready = t_alu[r];
                i_cmp_ready = t_cmp[r];
                i_rob_tag_ready = t_free[r];
                push_row(r);
                @(negedge clk);
                i_push = 1'b0;
                check("o_full", o_full, 1'b0);
                wait_drain();
                r++;
            end else begin
                holding = 1'b1;
                first = r;
                while (r < t_inst.size() && t_stall[r] == k) begin
                    @(negedge clk);
                    i_alu_ready = (k == 1) ? 1'b0 : t_alu[r];
                    i_cmp_ready = (k == 1) ? 1'b0 : t_cmp[r];
                    i_rob_tag_ready = (k == 2) ? 4'd0 : t_free[r];
                    push_row(r);
                    r++;
                end
                @(negedge clk);
                i_push = 1'b0;
                check("o_full", o_full, (r - first) == `IQ_DEPTH);
                repeat (4) @(negedge clk);
                holding = 1'b0;
                i_alu_ready = t_alu[r-1];
                i_cmp_ready = t_cmp[r-1];
                i_rob_tag_ready = t_free[r-1];
                repeat (r - first) begin
                    @(negedge clk);
                    if (!(o_alu_valid || o_cmp_valid)) begin
                        errors++;
                        $display("a held row did not come out in its cycle");
                    end
                end
                wait_drain();
            end
        end
        repeat (3) @(negedge clk);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rv_issue.f
+incdir+source
+incdir+sim
source/rv32i_pkg.sv
source/ooo_pkg.sv
source/inst_queue.sv
source/inst_fields.sv
source/operand_bypass.sv
source/issue_ctrl.sv
source/rv_issue_top.sv
sim/issue_tb.sv
